// ==== hdl/p3_agent_pkg.sv ====
`default_nettype none

// Agent-side types of the buffer rotation controller
// The three agents are the snooper, the processor and the forwarder
package p3_agent_pkg;

    // Agent code as seen on the per-buffer owner selects
    typedef logic [1:0] agent_id_t;

    // Code 0 marks a buffer that no agent is working on
    localparam agent_id_t AGENT_NONE = 2'd0;
    localparam agent_id_t AGENT_SN   = 2'd1;
    localparam agent_id_t AGENT_CPU  = 2'd2;
    localparam agent_id_t AGENT_FWD  = 2'd3;

    // Done events, already agreed with the agent, one strobe each
    // The processor ends a job with either an accept or a reject
    typedef struct packed {
        logic a_done;
        logic b_acc;
        logic b_rej;
        logic c_done;
    } done_ev_t;

    // One bit per agent, used for ready levels, acks and busy flags
    typedef struct packed {
        logic a;
        logic b;
        logic c;
    } agent_flags_t;

endpackage

`default_nettype wire

// ==== hdl/p3_buf_pkg.sv ====
`default_nettype none

// Buffer-side types of the buffer rotation controller
// Tokens that circulate between the queues are buffer identifiers
package p3_buf_pkg;

    // Number of packet buffers in rotation
    localparam int NUM_BUFS = 3;

    // Buffer identifier, also the mux select that an agent uses
    typedef logic [1:0] buf_id_t;

    localparam buf_id_t BUF_PING = 2'd0;
    localparam buf_id_t BUF_PANG = 2'd1;
    localparam buf_id_t BUF_PONG = 2'd2;

    // Agent view: which buffer sits at the head of each agent queue
    typedef struct packed {
        buf_id_t sn;
        buf_id_t cpu;
        buf_id_t fwd;
    } agent_sel_t;

    // Buffer view: which agent is active on each buffer, 0 for none
    typedef struct packed {
        p3_agent_pkg::agent_id_t ping;
        p3_agent_pkg::agent_id_t pang;
        p3_agent_pkg::agent_id_t pong;
    } owner_sel_t;

endpackage

`default_nettype wire

// ==== hdl/p3_token_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

// FIFO of buffer tokens with two enqueue ports and one dequeue strobe
// The head is read straight from the storage registers
module p3_token_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter bit INIT_FULL   = 1'b0
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      enq0_i,
    input  wire p3_buf_pkg::buf_id_t tok0_i,
    input  wire                      enq1_i,
    input  wire p3_buf_pkg::buf_id_t tok1_i,
    input  wire                      deq_i,
    output p3_buf_pkg::buf_id_t      head_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    p3_buf_pkg::buf_id_t mem [QUEUE_DEPTH];
    ptr_t rd_ptr;
    ptr_t wr_ptr;
    ptr_t wr_ptr_1;
    ptr_t wr_ptr_nxt;
    cnt_t count;

    // Pointer step with wrap, the depth need not be a power of two
    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Port 0 takes the first free slot, port 1 the one after it if both fire
    assign wr_ptr_1   = enq0_i ? ptr_inc(wr_ptr) : wr_ptr;
    assign wr_ptr_nxt = enq1_i ? ptr_inc(wr_ptr_1) : wr_ptr_1;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Slots start as ping, pang, pong in order
            // The count decides whether these tokens are live
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                mem[i] <= (i < p3_buf_pkg::NUM_BUFS) ? p3_buf_pkg::buf_id_t'(i)
                                                     : p3_buf_pkg::BUF_PING;
            end
            rd_ptr <= '0;
            wr_ptr <= INIT_FULL ? ptr_t'(p3_buf_pkg::NUM_BUFS % QUEUE_DEPTH) : '0;
            count  <= INIT_FULL ? cnt_t'(p3_buf_pkg::NUM_BUFS) : '0;
        end else begin
            if (enq0_i) begin
                mem[wr_ptr] <= tok0_i;
            end
            if (enq1_i) begin
                mem[wr_ptr_1] <= tok1_i;
            end
            if (deq_i) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            wr_ptr <= wr_ptr_nxt;
            count  <= count + cnt_t'(enq0_i) + cnt_t'(enq1_i) - cnt_t'(deq_i);
        end
    end

    assign head_o = mem[rd_ptr];

    // All three buffers fit at once, so a push past the depth is a routing fault
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        int'(count) + int'(enq0_i) + int'(enq1_i) <= QUEUE_DEPTH + int'(deq_i))
        else $error("token queue overflow");

    // A done strobe only comes from an agent that holds this queue's head
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        deq_i |-> (count != '0))
        else $error("token queue dequeue while empty");

    // Each buffer has one owner, so two tokens arriving together differ
    a_distinct_enq: assert property (@(posedge clk) disable iff (rst)
        (enq0_i && enq1_i) |-> (tok0_i != tok1_i))
        else $error("same buffer token enqueued twice");

endmodule

`default_nettype wire

// ==== hdl/p3_buf_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

// Token queues of the three agents and the routing between them
// A done event pops the agent's head and pushes it to the next agent
module p3_buf_tracker #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire p3_agent_pkg::done_ev_t ev_i,
    output p3_buf_pkg::agent_sel_t      agent_sel_o
);

    p3_buf_pkg::agent_sel_t heads;

    // Snooper queue holds every buffer after reset
    // Rejected packets and forwarded ones both come back here
    p3_token_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .INIT_FULL   (1'b1)
    ) i_sn_q (
        .clk    (clk),
        .rst    (rst),
        .enq0_i (ev_i.b_rej),
        .tok0_i (heads.cpu),
        .enq1_i (ev_i.c_done),
        .tok1_i (heads.fwd),
        .deq_i  (ev_i.a_done),
        .head_o (heads.sn)
    );

    // Processor queue is fed only by the snooper
    p3_token_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .INIT_FULL   (1'b0)
    ) i_cpu_q (
        .clk    (clk),
        .rst    (rst),
        .enq0_i (ev_i.a_done),
        .tok0_i (heads.sn),
        .enq1_i (1'b0),
        .tok1_i (p3_buf_pkg::BUF_PING),
        .deq_i  (ev_i.b_acc | ev_i.b_rej),
        .head_o (heads.cpu)
    );

    // Forwarder queue only sees accepted packets
    p3_token_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .INIT_FULL   (1'b0)
    ) i_fwd_q (
        .clk    (clk),
        .rst    (rst),
        .enq0_i (ev_i.b_acc),
        .tok0_i (heads.cpu),
        .enq1_i (1'b0),
        .tok1_i (p3_buf_pkg::BUF_PING),
        .deq_i  (ev_i.c_done),
        .head_o (heads.fwd)
    );

    assign agent_sel_o = heads;

endmodule

`default_nettype wire

// ==== hdl/p3_agent_sched.sv ====
`timescale 1ns/10ps
`default_nettype none

// Per-agent scheduling: waiting counts, ready levels and busy flags
// The count is the number of buffers queued for an agent and not yet started
module p3_agent_sched (
    input  wire                             clk,
    input  wire                             rst,
    input  wire p3_agent_pkg::done_ev_t     ev_i,
    input  wire p3_agent_pkg::agent_flags_t rdy_ack_i,
    output p3_agent_pkg::agent_flags_t      rdy_o,
    output p3_agent_pkg::agent_flags_t      busy_o
);

    // One spare bit above NUM_BUFS so a bad count is visible and does not wrap
    localparam int CNT_W = $clog2(p3_buf_pkg::NUM_BUFS + 2);

    typedef logic [CNT_W-1:0] cnt_t;

    cnt_t cnt_a;
    cnt_t cnt_b;
    cnt_t cnt_c;
    p3_agent_pkg::agent_flags_t busy_q;
    p3_agent_pkg::agent_flags_t start;
    logic b_done;

    // Processor finishes on either verdict
    assign b_done = ev_i.b_acc | ev_i.b_rej;

    // Ready waits for a queued buffer and an idle agent
    // It stays up while the agent withholds its ack
    assign rdy_o.a = (cnt_a != '0) && !busy_q.a;
    assign rdy_o.b = (cnt_b != '0) && !busy_q.b;
    assign rdy_o.c = (cnt_c != '0) && !busy_q.c;

    // Start event is the ready/ack cycle
    assign start = rdy_o & rdy_ack_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            // All buffers are empty and wait for the snooper
            cnt_a  <= cnt_t'(p3_buf_pkg::NUM_BUFS);
            cnt_b  <= '0;
            cnt_c  <= '0;
            busy_q <= '0;
        end else begin
            // Snooper gets buffers back from rejects and from the forwarder
            cnt_a <= cnt_a + cnt_t'(ev_i.b_rej) + cnt_t'(ev_i.c_done) - cnt_t'(start.a);
            cnt_b <= cnt_b + cnt_t'(ev_i.a_done) - cnt_t'(start.b);
            cnt_c <= cnt_c + cnt_t'(ev_i.b_acc) - cnt_t'(start.c);

            // Start needs idle and done needs busy, so both never meet
            busy_q.a <= start.a | (busy_q.a & ~ev_i.a_done);
            busy_q.b <= start.b | (busy_q.b & ~b_done);
            busy_q.c <= start.c | (busy_q.c & ~ev_i.c_done);
        end
    end

    assign busy_o = busy_q;

    // No agent can have more buffers waiting than exist
    a_cnt_bound: assert property (@(posedge clk) disable iff (rst)
        (cnt_a <= cnt_t'(p3_buf_pkg::NUM_BUFS)) &&
        (cnt_b <= cnt_t'(p3_buf_pkg::NUM_BUFS)) &&
        (cnt_c <= cnt_t'(p3_buf_pkg::NUM_BUFS)))
        else $error("agent waiting count above buffer count");

    // Done only from an agent that was started and has not yet finished
    // The tracker pops heads on these strobes, so a stray one corrupts the queues
    a_done_busy: assert property (@(posedge clk) disable iff (rst)
        (!ev_i.a_done || busy_q.a) &&
        (!b_done || busy_q.b) &&
        (!ev_i.c_done || busy_q.c))
        else $error("done strobe from an idle agent");

    // Processor gives one verdict per packet
    a_one_verdict: assert property (@(posedge clk) disable iff (rst)
        !(ev_i.b_acc && ev_i.b_rej))
        else $error("processor accept and reject together");

endmodule

`default_nettype wire

// ==== hdl/p3_sel_map.sv ====
`timescale 1ns/10ps
`default_nettype none

// Turns the per-agent buffer selects into per-buffer owner selects
// Only busy agents own a buffer, an idle agent's head is just waiting
module p3_sel_map (
    input  wire p3_buf_pkg::agent_sel_t     agent_sel_i,
    input  wire p3_agent_pkg::agent_flags_t busy_i,
    output p3_buf_pkg::owner_sel_t          owner_sel_o
);

    logic clash;

    // Code of the busy agent working on buffer b, or none
    function automatic p3_agent_pkg::agent_id_t owner_of(
        p3_buf_pkg::agent_sel_t     sel,
        p3_agent_pkg::agent_flags_t busy,
        p3_buf_pkg::buf_id_t        b
    );
        p3_agent_pkg::agent_id_t id;
        id = p3_agent_pkg::AGENT_NONE;
        if (busy.a && (sel.sn == b)) begin
            id = p3_agent_pkg::AGENT_SN;
        end else if (busy.b && (sel.cpu == b)) begin
            id = p3_agent_pkg::AGENT_CPU;
        end else if (busy.c && (sel.fwd == b)) begin
            id = p3_agent_pkg::AGENT_FWD;
        end
        return id;
    endfunction

    assign owner_sel_o.ping = owner_of(agent_sel_i, busy_i, p3_buf_pkg::BUF_PING);
    assign owner_sel_o.pang = owner_of(agent_sel_i, busy_i, p3_buf_pkg::BUF_PANG);
    assign owner_sel_o.pong = owner_of(agent_sel_i, busy_i, p3_buf_pkg::BUF_PONG);

    // Heads come from the tracker and busy from the scheduler
    // Two busy agents on one buffer means the two have drifted apart
    always_comb begin
        clash = (busy_i.a && busy_i.b && (agent_sel_i.sn == agent_sel_i.cpu)) ||
                (busy_i.a && busy_i.c && (agent_sel_i.sn == agent_sel_i.fwd)) ||
                (busy_i.b && busy_i.c && (agent_sel_i.cpu == agent_sel_i.fwd));
        // Unknown flags before the first reset edge are not a clash
        a_no_share: assert final (clash !== 1'b1)
            else $error("two busy agents on one buffer");
    end

endmodule

`default_nettype wire

// ==== hdl/p3ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// Buffer rotation controller of the packet filter core
// Scheduler and tracker run side by side on the same done events
module p3ctrl_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             a_done_i,
    input  wire                             b_acc_i,
    input  wire                             b_rej_i,
    input  wire                             c_done_i,
    input  wire p3_agent_pkg::agent_flags_t rdy_ack_i,
    output p3_agent_pkg::agent_flags_t      rdy_o,
    output p3_buf_pkg::agent_sel_t          agent_sel_o,
    output p3_buf_pkg::owner_sel_t          owner_sel_o
);

    wire p3_agent_pkg::done_ev_t     ev;
    wire p3_agent_pkg::agent_flags_t busy;
    wire p3_buf_pkg::agent_sel_t     agent_sel;

    // Done strobes are bundled as they come, no ack is needed
    assign ev = '{a_done: a_done_i, b_acc: b_acc_i, b_rej: b_rej_i, c_done: c_done_i};

    p3_agent_sched i_sched (
        .clk       (clk),
        .rst       (rst),
        .ev_i      (ev),
        .rdy_ack_i (rdy_ack_i),
        .rdy_o     (rdy_o),
        .busy_o    (busy)
    );

    p3_buf_tracker #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_tracker (
        .clk         (clk),
        .rst         (rst),
        .ev_i        (ev),
        .agent_sel_o (agent_sel)
    );

    // Agent view goes out as is, buffer view is derived from it
    p3_sel_map i_sel_map (
        .agent_sel_i (agent_sel),
        .busy_i      (busy),
        .owner_sel_o (owner_sel_o)
    );

    assign agent_sel_o = agent_sel;

endmodule

`default_nettype wire

// ==== tb/tb_p3ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// Testbench for the buffer rotation controller
// Three agent models move the buffers around while a queue model predicts the outputs
module tb_p3ctrl_top;

    localparam int QUEUE_DEPTH    = 4;
    localparam int TXN_TOTAL      = 400;
    // Agent activity per transaction stays within about six cycles
    localparam int TXN_CYCLES     = 6;
    localparam int TIMEOUT_CYCLES = TXN_TOTAL * TXN_CYCLES + 600;

    typedef enum logic [2:0] {AG_IDLE, AG_WAIT, AG_ACK, AG_WORK, AG_DONE} ag_phase_t;

    logic clk    = 1'b0;
    logic rst    = 1'b1;
    logic a_done = 1'b0;
    logic b_acc  = 1'b0;
    logic b_rej  = 1'b0;
    logic c_done = 1'b0;
    p3_agent_pkg::agent_flags_t rdy_ack = '0;
    p3_agent_pkg::agent_flags_t rdy;
    p3_buf_pkg::agent_sel_t     agent_sel;
    p3_buf_pkg::owner_sel_t     owner_sel;

    // Agent index 2 is the snooper, 1 the processor and 0 the forwarder
    // This matches the bit order of the flag struct
    logic [2:0] rdy_vec;
    logic [2:0] ack_vec;

    ag_phase_t   phase [3];
    int unsigned wait_cnt [3];
    int unsigned work_cnt [3];
    int started_cnt;
    int finished_cnt;
    int accepted_cnt;
    int rejected_cnt;
    int cycle_cnt = 0;

    // Reference token queues and the expected outputs derived from them
    p3_buf_pkg::buf_id_t    q_sn [$];
    p3_buf_pkg::buf_id_t    q_cpu [$];
    p3_buf_pkg::buf_id_t    q_fwd [$];
    logic [2:0]             m_busy;
    logic [2:0]             exp_nonempty;
    logic [2:0]             exp_rdy;
    p3_buf_pkg::agent_sel_t exp_head;
    p3_buf_pkg::owner_sel_t exp_owner;

    p3ctrl_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .a_done_i    (a_done),
        .b_acc_i     (b_acc),
        .b_rej_i     (b_rej),
        .c_done_i    (c_done),
        .rdy_ack_i   (rdy_ack),
        .rdy_o       (rdy),
        .agent_sel_o (agent_sel),
        .owner_sel_o (owner_sel)
    );

    assign rdy_vec = rdy;
    assign ack_vec = rdy_ack;

    always #20 clk = ~clk;

    task automatic end_in_failure(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // Writes an agent code into the field of buffer b
    function automatic p3_buf_pkg::owner_sel_t mark_owner(p3_buf_pkg::owner_sel_t o,
            p3_buf_pkg::buf_id_t b, p3_agent_pkg::agent_id_t code);
        p3_buf_pkg::owner_sel_t r;
        r = o;
        case (b)
            p3_buf_pkg::BUF_PING: r.ping = code;
            p3_buf_pkg::BUF_PANG: r.pang = code;
            default:              r.pong = code;
        endcase
        return r;
    endfunction

    // True when no nonzero agent code shows up on two buffers
    function automatic bit owner_codes_distinct(p3_buf_pkg::owner_sel_t o);
        return ((o.ping == '0) || ((o.ping != o.pang) && (o.ping != o.pong))) &&
               ((o.pang == '0) || (o.pang != o.pong));
    endfunction

    // Each agent model waits 0 to 3 cycles before the ack and then works 1 to 5 cycles
    always @(posedge clk) begin : agent_models
        logic [2:0] ack_nxt;
        logic [2:0] done_nxt;
        logic       accept;
        ack_nxt  = 3'b000;
        done_nxt = 3'b000;
        accept   = 1'b0;
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                phase[i] = AG_IDLE;
            end
            started_cnt  = 0;
            finished_cnt = 0;
            accepted_cnt = 0;
            rejected_cnt = 0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                case (phase[i])
                    AG_IDLE: begin
                        if (rdy_vec[i] && (started_cnt < TXN_TOTAL)) begin
                            started_cnt++;
                            wait_cnt[i] = $urandom % 4;
                            if (wait_cnt[i] == 0) begin
                                ack_nxt[i] = 1'b1;
                                phase[i]   = AG_ACK;
                            end else begin
                                phase[i] = AG_WAIT;
                            end
                        end
                    end
                    AG_WAIT: begin
                        // Ready holds here while the ack is withheld
                        wait_cnt[i]--;
                        if (wait_cnt[i] == 0) begin
                            ack_nxt[i] = 1'b1;
                            phase[i]   = AG_ACK;
                        end
                    end
                    AG_ACK: begin
                        work_cnt[i] = 1 + ($urandom % 5);
                        phase[i]    = AG_WORK;
                    end
                    AG_WORK: begin
                        work_cnt[i]--;
                        if (work_cnt[i] == 0) begin
                            done_nxt[i] = 1'b1;
                            phase[i]    = AG_DONE;
                        end
                    end
                    default: begin
                        finished_cnt++;
                        phase[i] = AG_IDLE;
                    end
                endcase
            end
            // The processor picks its verdict at random
            if (done_nxt[1]) begin
                accept = (($urandom % 2) == 0);
                if (accept) begin
                    accepted_cnt++;
                end else begin
                    rejected_cnt++;
                end
            end
        end
        rdy_ack <= p3_agent_pkg::agent_flags_t'(ack_nxt);
        a_done  <= done_nxt[2];
        b_acc   <= done_nxt[1] && accept;
        b_rej   <= done_nxt[1] && !accept;
        c_done  <= done_nxt[0];
    end

    // The queue model moves an agent's head on at its done
    // Rejected and forwarded buffers go back to the snooper
    always @(posedge clk) begin : queue_model
        p3_buf_pkg::buf_id_t    h_sn;
        p3_buf_pkg::buf_id_t    h_cpu;
        p3_buf_pkg::buf_id_t    h_fwd;
        logic [2:0]             nonempty;
        p3_buf_pkg::owner_sel_t owner;
        if (rst) begin
            // Snooper queue starts with every buffer in id order
            q_sn.delete();
            q_cpu.delete();
            q_fwd.delete();
            for (int b = 0; b < p3_buf_pkg::NUM_BUFS; b++) begin
                q_sn.push_back(p3_buf_pkg::buf_id_t'(b));
            end
            m_busy = 3'b000;
        end else begin
            nonempty = {q_sn.size() != 0, q_cpu.size() != 0, q_fwd.size() != 0};
            h_sn  = (q_sn.size() != 0) ? q_sn[0] : p3_buf_pkg::BUF_PING;
            h_cpu = (q_cpu.size() != 0) ? q_cpu[0] : p3_buf_pkg::BUF_PING;
            h_fwd = (q_fwd.size() != 0) ? q_fwd[0] : p3_buf_pkg::BUF_PING;
            // An ack while the model says ready starts the agent and its done ends it
            m_busy = (nonempty & ~m_busy & ack_vec) |
                     (m_busy & ~{a_done, b_acc | b_rej, c_done});
            if (a_done) begin
                void'(q_sn.pop_front());
                q_cpu.push_back(h_sn);
            end
            if (b_acc || b_rej) begin
                void'(q_cpu.pop_front());
            end
            if (c_done) begin
                void'(q_fwd.pop_front());
            end
            // A reject reaches the snooper tail ahead of a forwarded buffer
            if (b_rej) begin
                q_sn.push_back(h_cpu);
            end
            if (b_acc) begin
                q_fwd.push_back(h_cpu);
            end
            if (c_done) begin
                q_sn.push_back(h_fwd);
            end
        end
        nonempty = {q_sn.size() != 0, q_cpu.size() != 0, q_fwd.size() != 0};
        owner = '0;
        if (m_busy[2]) begin
            owner = mark_owner(owner, q_sn[0], p3_agent_pkg::AGENT_SN);
        end
        if (m_busy[1]) begin
            owner = mark_owner(owner, q_cpu[0], p3_agent_pkg::AGENT_CPU);
        end
        if (m_busy[0]) begin
            owner = mark_owner(owner, q_fwd[0], p3_agent_pkg::AGENT_FWD);
        end
        exp_nonempty <= nonempty;
        exp_rdy      <= nonempty & ~m_busy;
        exp_head.sn  <= (q_sn.size() != 0) ? q_sn[0] : p3_buf_pkg::BUF_PING;
        exp_head.cpu <= (q_cpu.size() != 0) ? q_cpu[0] : p3_buf_pkg::BUF_PING;
        exp_head.fwd <= (q_fwd.size() != 0) ? q_fwd[0] : p3_buf_pkg::BUF_PING;
        exp_owner    <= owner;
    end

    // Snooper alone is ready on ping and no buffer is owned
    a_reset_state: assert property (@(posedge clk)
        $fell(rst) |-> (rdy_vec == 3'b100) && (owner_sel == '0) &&
                       (agent_sel.sn == p3_buf_pkg::BUF_PING))
        else end_in_failure($sformatf("MISMATCH at %0d ns: reset state rdy %b sel %h owner %h",
            $time, $sampled(rdy_vec), $sampled(agent_sel), $sampled(owner_sel)));

    // Heads of non-empty queues follow the model on both the accept and the reject path
    a_heads: assert property (@(posedge clk) disable iff (rst)
        (!exp_nonempty[2] || (agent_sel.sn == exp_head.sn)) &&
        (!exp_nonempty[1] || (agent_sel.cpu == exp_head.cpu)) &&
        (!exp_nonempty[0] || (agent_sel.fwd == exp_head.fwd)))
        else end_in_failure($sformatf("MISMATCH at %0d ns: agent_sel %h expected %h valid %b",
            $time, $sampled(agent_sel), $sampled(exp_head), $sampled(exp_nonempty)));

    a_ready: assert property (@(posedge clk) disable iff (rst)
        rdy_vec == exp_rdy)
        else end_in_failure($sformatf("MISMATCH at %0d ns: rdy %b expected %b",
            $time, $sampled(rdy_vec), $sampled(exp_rdy)));

    // A ready without its ack must still be there a cycle later
    a_ready_hold: assert property (@(posedge clk) disable iff (rst)
        (($past(rdy_vec) & ~$past(ack_vec)) & ~rdy_vec) == 3'b000)
        else end_in_failure($sformatf("Ready dropped before its ack at %0d ns", $time));

    a_owner: assert property (@(posedge clk) disable iff (rst)
        owner_sel == exp_owner)
        else end_in_failure($sformatf("MISMATCH at %0d ns: owner_sel %h expected %h",
            $time, $sampled(owner_sel), $sampled(exp_owner)));

    a_owner_distinct: assert property (@(posedge clk) disable iff (rst)
        owner_codes_distinct(owner_sel))
        else end_in_failure($sformatf("One agent owns two buffers at %0d ns", $time));

    always @(posedge clk) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            end_in_failure($sformatf("Timeout after %0d cycles with %0d of %0d transactions done",
                cycle_cnt, finished_cnt, TXN_TOTAL));
        end
    end

    initial begin : main_sequence
        void'($urandom(32'heb9e));
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        while (finished_cnt < TXN_TOTAL) begin
            @(posedge clk);
        end
        // Let the last done strobe reach the checks
        repeat (3) @(posedge clk);
        $display("%0d transactions, %0d accepted, %0d rejected",
                 finished_cnt, accepted_cnt, rejected_cnt);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== p3ctrl_top.f ====
hdl/p3_agent_pkg.sv
hdl/p3_buf_pkg.sv
hdl/p3_token_queue.sv
hdl/p3_buf_tracker.sv
hdl/p3_agent_sched.sv
hdl/p3_sel_map.sv
hdl/p3ctrl_top.sv
tb/tb_p3ctrl_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_p3ctrl_top
FILELIST   := p3ctrl_top.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert -Wall
SIM_FLAGS  := --binary --timing --assert --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
